//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -f vlog.f \
    --top-module bp_frontend_tb -o bp_frontend_sim

output=$(./obj_dir/bp_frontend_sim)
echo "$output"

if echo "$output" | grep -q "^Regression passed$"; then
    exit 0
fi
exit 1

//--- source/bp_frontend_top.sv
`timescale 1ns/10ps

module bp_frontend_top import bpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        ds_allowin,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    input  logic [31:0] res_pc,
    input  pht_count_t  res_old_count,
    input  logic        res_is_branch,
    input  logic        res_taken,
    input  logic [31:0] res_target,
    output logic [31:0] fs_pc,
    output logic        pred_valid,
    output logic        pred_taken,
    output pht_count_t  pred_count,
    output logic [31:0] pred_target
);

    logic                   lookup_hit;
    logic [31:0]            lookup_target;
    logic                   pht_we;
    logic [PHT_INDEX_W-1:0] pht_wr_index;
    pht_entry_t             pht_wr_entry;

    fetch_pc_gen fetch_pc_gen_i (
        .clk            (clk),
        .reset          (reset),
        .ds_allowin     (ds_allowin),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .lookup_hit     (lookup_hit),
        .lookup_target  (lookup_target),
        .fs_pc          (fs_pc)
    );

    bpu bpu_i (
        .clk           (clk),
        .reset         (reset),
        .fs_pc         (fs_pc),
        .ds_allowin    (ds_allowin),
        .pht_we        (pht_we),
        .pht_wr_index  (pht_wr_index),
        .pht_wr_entry  (pht_wr_entry),
        .lookup_hit    (lookup_hit),
        .lookup_target (lookup_target),
        .pred_valid    (pred_valid),
        .pred_taken    (pred_taken),
        .pred_count    (pred_count),
        .pred_target   (pred_target)
    );

    pht_update pht_update_i (
        .clk           (clk),
        .reset         (reset),
        .res_pc        (res_pc),
        .res_old_count (res_old_count),
        .res_is_branch (res_is_branch),
        .res_taken     (res_taken),
        .res_target    (res_target),
        .pht_we        (pht_we),
        .pht_wr_index  (pht_wr_index),
        .pht_wr_entry  (pht_wr_entry)
    );

endmodule

//--- source/bpu.sv
`timescale 1ns/10ps

module bpu import bpu_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [31:0]            fs_pc,
    input  logic                   ds_allowin,
    input  logic                   pht_we,
    input  logic [PHT_INDEX_W-1:0] pht_wr_index,
    input  pht_entry_t             pht_wr_entry,
    output logic                   lookup_hit,
    output logic [31:0]            lookup_target,
    output logic                   pred_valid,
    output logic                   pred_taken,
    output pht_count_t             pred_count,
    output logic [31:0]            pred_target
);

    logic [PHT_INDEX_W-1:0] fs_index;
    logic [PHT_TAG_W-1:0]   fs_tag;
    logic [PHT_INDEX_W-1:0] ram_addr;
    pht_entry_t             rd_entry;

    assign fs_index = fs_pc[PHT_INDEX_W+1:2];
    assign fs_tag   = fs_pc[31:PHT_INDEX_W+2];

    // single port, so a write steals the address from fetch
    assign ram_addr = pht_we ? pht_wr_index : fs_index;

    pht_lutram #(
        .entry_t (pht_entry_t),
        .DEPTH   (PHT_ENTRIES)
    ) pht_ram_i (
        .clk   (clk),
        .we    (pht_we),
        .addr  (ram_addr),
        .wdata (pht_wr_entry),
        .rdata (rd_entry)
    );

    // read data belongs to the write index while pht_we is up
    assign lookup_hit = (rd_entry.tag == fs_tag) && !pht_we;

    // not taken still skips the delay slot
    assign lookup_target = rd_entry.count[1] ? fs_pc + 32'd8 : rd_entry.target;

    always_ff @(posedge clk) begin
        if (reset) begin
            pred_valid  <= 1'b0;
            pred_taken  <= 1'b0;
            pred_count  <= WEAK_TAKEN;
            pred_target <= 32'd0;
        end else if (ds_allowin) begin
            if (lookup_hit) begin
                pred_valid  <= 1'b1;
                pred_taken  <= ~rd_entry.count[1];
                pred_count  <= rd_entry.count;
                pred_target <= lookup_target;
            end else begin
                pred_valid  <= 1'b0; // miss clears the whole prediction
                pred_taken  <= 1'b0;
                pred_count  <= WEAK_TAKEN;
                pred_target <= 32'd0;
            end
        end
    end

endmodule

//--- source/bpu_pkg.sv
package bpu_pkg;

    // table geometry, direct mapped on the word address
    localparam int PHT_ENTRIES = 256;
    localparam int PHT_INDEX_W = 8;  // pc[9:2]
    localparam int PHT_TAG_W   = 22; // pc[31:10]

    localparam logic [31:0] RESET_PC = 32'hbfc0_0000; // boot vector

    // 2-bit saturating counter
    // bit 1 set means predict not taken
    typedef enum logic [1:0] {
        WEAK_TAKEN       = 2'b00,
        STRONG_TAKEN     = 2'b01,
        WEAK_NOT_TAKEN   = 2'b10,
        STRONG_NOT_TAKEN = 2'b11
    } pht_count_t;

    // one table line, count in the top two bits
    typedef struct packed {
        pht_count_t             count;
        logic [PHT_TAG_W-1:0]   tag;
        logic [31:0]            target;
    } pht_entry_t;

endpackage

//--- source/fetch_pc_gen.sv
`timescale 1ns/10ps

module fetch_pc_gen import bpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        ds_allowin,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    input  logic        lookup_hit,
    input  logic [31:0] lookup_target,
    output logic [31:0] fs_pc
);

    logic        pend_valid;  // target waiting behind the delay slot
    logic [31:0] pend_target;
    logic [31:0] pc_next;
    logic        arm;

    // redirect, then pending target, then sequential
    always_comb begin
        arm = 1'b0;
        if (redirect_valid) begin
            pc_next = redirect_pc;
        end else if (pend_valid) begin
            pc_next = pend_target;
        end else begin
            pc_next = fs_pc + 32'd4; // next is the delay slot on a hit
            arm     = lookup_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc      <= RESET_PC;
            pend_valid <= 1'b0;
        end else if (redirect_valid || ds_allowin) begin
            fs_pc      <= pc_next;
            pend_valid <= arm && ds_allowin;
        end
    end

    always_ff @(posedge clk) begin
        if (arm && ds_allowin) begin
            pend_target <= lookup_target;
        end
    end

endmodule

//--- source/pht_lutram.sv
`timescale 1ns/10ps

module pht_lutram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 256
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    entry_t mem [DEPTH]; // distributed ram, no reset port

    // empty lines read back with tag zero
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr]; // async read, same address as the write

endmodule

//--- source/pht_update.sv
`timescale 1ns/10ps

module pht_update import bpu_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [31:0]            res_pc,
    input  pht_count_t             res_old_count,
    input  logic                   res_is_branch,
    input  logic                   res_taken,
    input  logic [31:0]            res_target,
    output logic                   pht_we,
    output logic [PHT_INDEX_W-1:0] pht_wr_index,
    output pht_entry_t             pht_wr_entry
);

    logic [31:0] res_pc_q;
    pht_count_t  res_old_count_q;
    logic        res_is_branch_q;
    logic        res_taken_q;
    logic [31:0] res_target_q;
    pht_count_t  new_count;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_is_branch_q <= 1'b0;
        end else begin
            res_is_branch_q <= res_is_branch;
        end
    end

    always_ff @(posedge clk) begin
        res_pc_q        <= res_pc;
        res_old_count_q <= res_old_count;
        res_taken_q     <= res_taken;
        res_target_q    <= res_target;
    end

    // one step per outcome, saturating at both strong states
    always_comb begin
        case (res_old_count_q)
            STRONG_NOT_TAKEN: new_count = res_taken_q ? WEAK_NOT_TAKEN : STRONG_NOT_TAKEN;
            WEAK_NOT_TAKEN:   new_count = res_taken_q ? WEAK_TAKEN     : STRONG_NOT_TAKEN;
            WEAK_TAKEN:       new_count = res_taken_q ? STRONG_TAKEN   : WEAK_NOT_TAKEN;
            STRONG_TAKEN:     new_count = res_taken_q ? STRONG_TAKEN   : WEAK_TAKEN;
            default:          new_count = WEAK_TAKEN;
        endcase
    end

    assign pht_we       = res_is_branch_q;
    assign pht_wr_index = res_pc_q[PHT_INDEX_W+1:2];
    assign pht_wr_entry = '{count:  new_count,
                            tag:    res_pc_q[31:PHT_INDEX_W+2],
                            target: res_target_q};

endmodule

//--- testbench/bp_frontend_tb.sv
`timescale 1ns/10ps

module bp_frontend_tb import bpu_pkg::*;;

    localparam int SEED        = 56355;
    localparam int IDLE_CYCLES = 40;   // empty table, plain sequential fetch
    localparam int SAT_START   = 2200; // single pc counter walk from here
    localparam int NUM_CYCLES  = 3000;
    localparam int MAX_CYCLES  = 4 * NUM_CYCLES + 100;

    logic        clk;
    logic        reset;
    logic        ds_allowin;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic [31:0] res_pc;
    pht_count_t  res_old_count;
    logic        res_is_branch;
    logic        res_taken;
    logic [31:0] res_target;
    logic [31:0] fs_pc;
    logic        pred_valid;
    logic        pred_taken;
    pht_count_t  pred_count;
    logic [31:0] pred_target;

    // reference model state
    pht_entry_t  model_pht [PHT_ENTRIES];
    logic [31:0] m_fs_pc;
    logic        m_pend_valid;
    logic [31:0] m_pend_target;
    logic        m_pred_valid;
    logic        m_pred_taken;
    pht_count_t  m_pred_count;
    logic [31:0] m_pred_target;
    logic        pipe_is_branch; // resolution registered at the last edge
    logic [31:0] pipe_pc;
    pht_count_t  pipe_count;
    logic        pipe_taken;
    logic [31:0] pipe_target;
    pht_count_t  sat_count;      // newest count of the walked pc

    int pc_errors    = 0;
    int count_errors = 0;
    int flag_errors  = 0;
    int entry_errors = 0;
    int pred_seen    = 0;
    int cycle_count  = 0;

    logic [3:0] counts_seen = 4'b0000; // counter states decode has seen

    tb_clock clock_gen_i (
        .clk (clk)
    );

    bp_frontend_top bp_frontend_top_i (
        .clk            (clk),
        .reset          (reset),
        .ds_allowin     (ds_allowin),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .res_pc         (res_pc),
        .res_old_count  (res_old_count),
        .res_is_branch  (res_is_branch),
        .res_taken      (res_taken),
        .res_target     (res_target),
        .fs_pc          (fs_pc),
        .pred_valid     (pred_valid),
        .pred_taken     (pred_taken),
        .pred_count     (pred_count),
        .pred_target    (pred_target)
    );

    task automatic check_pc(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            pc_errors++;
        end
    endtask

    task automatic check_count(input string what, input pht_count_t got, input pht_count_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            count_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            flag_errors++;
        end
    endtask

    task automatic check_entry(input string what, input pht_entry_t got, input pht_entry_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %b/%h/%h, expected %b/%h/%h", $time, what,
                     got.count, got.tag, got.target, exp.count, exp.tag, exp.target);
            entry_errors++;
        end
    endtask

    // counter as a strength level, 0 strong taken up to 3 strong not taken
    function automatic pht_count_t step_count(input pht_count_t old, input logic taken);
        int level;
        case (old)
            STRONG_TAKEN:   level = 0;
            WEAK_TAKEN:     level = 1;
            WEAK_NOT_TAKEN: level = 2;
            default:        level = 3;
        endcase
        if (taken && level > 0) begin
            level = level - 1;
        end else if (!taken && level < 3) begin
            level = level + 1;
        end
        case (level)
            0:       return STRONG_TAKEN;
            1:       return WEAK_TAKEN;
            2:       return WEAK_NOT_TAKEN;
            default: return STRONG_NOT_TAKEN;
        endcase
    endfunction

    function automatic pht_entry_t expected_write();
        pht_entry_t e;
        e.count  = step_count(pipe_count, pipe_taken);
        e.tag    = pipe_pc[31:10];
        e.target = pipe_target;
        return e;
    endfunction

    // small tag pool and low indexes so hits and aliasing both happen
    function automatic logic [31:0] random_pc();
        logic [31:0] r;
        logic [21:0] tag;
        r = $urandom();
        case (r[1:0])
            2'd0:    tag = 22'h000001;
            2'd1:    tag = 22'h2ff000; // same tag as the boot vector
            2'd2:    tag = 22'h15a5a5;
            default: tag = 22'h000003;
        endcase
        return {tag, 4'b0000, r[5:2], 2'b00};
    endfunction

    task automatic model_reset();
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            model_pht[i] = '0;
        end
        m_fs_pc        = RESET_PC;
        m_pend_valid   = 1'b0;
        m_pend_target  = 32'd0;
        m_pred_valid   = 1'b0;
        m_pred_taken   = 1'b0;
        m_pred_count   = WEAK_TAKEN;
        m_pred_target  = 32'd0;
        pipe_is_branch = 1'b0;
        pipe_pc        = 32'd0;
        pipe_count     = WEAK_TAKEN;
        pipe_taken     = 1'b0;
        pipe_target    = 32'd0;
        sat_count      = WEAK_NOT_TAKEN;
    endtask

    task automatic check_outputs();
        check_pc("fs_pc", fs_pc, m_fs_pc);
        check_flag("pred_valid", pred_valid, m_pred_valid);
        check_flag("pred_taken", pred_taken, m_pred_taken);
        check_count("pred_count", pred_count, m_pred_count);
        check_pc("pred_target", pred_target, m_pred_target);
        check_flag("pht_we", bp_frontend_top_i.pht_we, pipe_is_branch);
        if (pipe_is_branch) begin
            check_entry("pht_wr_entry", bp_frontend_top_i.pht_wr_entry, expected_write());
        end
        if (pred_valid) begin
            pred_seen++;
            counts_seen[pred_count] = 1'b1;
        end
    endtask

    task automatic drive_inputs(input int cyc);
        logic [31:0] r;
        pht_entry_t  cur;
        logic        bias_taken;
        r = $urandom();
        redirect_valid = 1'b0;
        res_is_branch  = 1'b0;
        if (cyc < IDLE_CYCLES) begin
            ds_allowin = (r[1:0] != 2'b00);
        end else if (cyc < SAT_START) begin
            ds_allowin     = (r[2:0] != 3'b000);
            redirect_valid = (r[5:3] == 3'b000);
            redirect_pc    = random_pc();
            res_is_branch  = r[6];
            res_pc         = random_pc();
            res_taken      = r[7];
            res_target     = random_pc();
            cur = model_pht[res_pc[9:2]];
            if (cur.tag == res_pc[31:10]) begin
                res_old_count = cur.count; // branch carries what fetch saw
            end else begin
                res_old_count = pht_count_t'(r[9:8]);
            end
        end else begin
            bias_taken     = (((cyc - SAT_START) / 40) % 2) == 0;
            ds_allowin     = (r[1:0] != 2'b00);
            redirect_valid = (cyc % 4 == 0);
            redirect_pc    = 32'h5696_9480; // tag 15a5a5, index 20
            res_is_branch  = r[2];
            res_pc         = 32'h5696_9480;
            res_target     = 32'h0000_0500;
            res_taken      = bias_taken ^ (r[7:4] >= 4'd12); // mostly follows the bias
            res_old_count  = sat_count;
            if (res_is_branch) begin
                sat_count = step_count(sat_count, res_taken);
            end
        end
    endtask

    // next state at the coming rising edge, from the inputs just driven
    task automatic model_step();
        pht_entry_t  wr_entry;
        pht_entry_t  rd;
        logic        hit;
        logic [31:0] tgt;
        wr_entry = expected_write();
        rd       = model_pht[m_fs_pc[9:2]];
        hit      = !pipe_is_branch && (rd.tag == m_fs_pc[31:10]);
        tgt      = rd.count[1] ? m_fs_pc + 32'd8 : rd.target;
        if (ds_allowin) begin
            m_pred_valid  = hit;
            m_pred_taken  = hit && !rd.count[1];
            m_pred_count  = hit ? rd.count : WEAK_TAKEN;
            m_pred_target = hit ? tgt : 32'd0;
        end
        if (redirect_valid) begin
            m_fs_pc      = redirect_pc;
            m_pend_valid = 1'b0;
        end else if (ds_allowin) begin
            if (m_pend_valid) begin
                m_fs_pc      = m_pend_target;
                m_pend_valid = 1'b0;
            end else begin
                m_fs_pc      = m_fs_pc + 32'd4; // delay slot
                m_pend_valid = hit;
                if (hit) begin
                    m_pend_target = tgt;
                end
            end
        end
        if (pipe_is_branch) begin
            model_pht[pipe_pc[9:2]] = wr_entry;
        end
        pipe_is_branch = res_is_branch;
        pipe_pc        = res_pc;
        pipe_count     = res_old_count;
        pipe_taken     = res_taken;
        pipe_target    = res_target;
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        int seed_ret;
        int cyc;
        int total;
        seed_ret       = $urandom(SEED);
        reset          = 1'b1;
        ds_allowin     = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = 32'd0;
        res_pc         = 32'd0;
        res_old_count  = WEAK_TAKEN;
        res_is_branch  = 1'b0;
        res_taken      = 1'b0;
        res_target     = 32'd0;
        model_reset();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            check_outputs();
            drive_inputs(cyc);
            model_step();
            @(negedge clk);
        end
        check_outputs();
        $display("predictions seen by decode: %0d", pred_seen);
        total = pc_errors + count_errors + flag_errors + entry_errors;
        if (counts_seen != 4'b1111) begin
            $display("Decode never saw some counter states, seen mask is %b", counts_seen);
            total++;
        end
        $display("errors: %0d pc, %0d count, %0d flag, %0d entry",
                 pc_errors, count_errors, flag_errors, entry_errors);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk; // half period per phase

endmodule

//--- vlog.f
source/bpu_pkg.sv
source/pht_lutram.sv
source/pht_update.sv
source/bpu.sv
source/fetch_pc_gen.sv
source/bp_frontend_top.sv
testbench/tb_clock.sv
testbench/bp_frontend_tb.sv
